//--- memSys.f
+incdir+test
src/memPkg.sv
src/byteRam.sv
src/memCtrl.sv
src/memSys.sv
test/memSysTb.sv

//--- run.sh
#!/bin/sh
# build and run memSysTb with Verilator, fail on any error in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f memSys.f --top-module memSysTb -o memSysSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/memSysSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- src/byteRam.sv
`timescale 1ns/10ps

module byteRam
    import memPkg::*;
(
    input  logic  clk,
    input  addr_t memAddr,
    input  logic  memWe,
    input  byte_t memWdata,
    input  logic  memRe,
    output byte_t memRdata
);

    byte_t mem [2**RAM_ADDR_BITS];

    logic [RAM_ADDR_BITS-1:0] idx;

    // upper address bits fold onto the array
    assign idx = memAddr[RAM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (memWe) begin
            mem[idx] <= memWdata;
        end
    end

    // read register only moves when asked, so a byte survives a stall
    always_ff @(posedge clk) begin
        if (memRe) begin
            memRdata <= mem[idx];
        end
    end

endmodule

//--- src/memCtrl.sv
`timescale 1ns/10ps

module memCtrl
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   ioFull,

    // instruction fetch port
    input  logic   fetchEn,
    input  addr_t  fetchAddr,
    output logic   fetchDone,
    output word_t  fetchInst,

    // load/store port
    input  logic   dataEn,
    input  logic   dataStore,
    input  len_t   dataLen,
    input  addr_t  dataAddr,
    input  word_t  dataWdata,
    output logic   dataDone,
    output word_t  dataRdata,

    output owner_t owner,

    // byte RAM side
    output addr_t  memAddr,
    output logic   memWe,
    output byte_t  memWdata,
    output logic   memRe,
    input  byte_t  memRdata
);

    ctrlState_t state;
    len_t       stage;

    // latched request
    len_t       lenReg;
    addr_t      baseAddr;
    word_t      storeData;

    // bytes collected so far on a fetch or load
    word_t      asmWord;

    logic       go;
    logic       accept;
    logic       lastStage;
    logic       reading;
    logic [1:0] captIdx;
    logic [1:0] wrIdx;

    // frozen whenever the core is not ready or the io buffer is full
    assign go = rdy && !ioFull;

    assign accept  = (state == Idle) && go && (dataEn || fetchEn);
    assign reading = (state == Fetch) || (state == Load);

    // byte returning now was requested one stage earlier
    assign captIdx = stage[1:0] - 2'd1;
    assign wrIdx   = stage[1:0];

    always_comb begin
        case (state)
            Fetch,
            Load: begin
                // one extra stage to take the last byte off the RAM
                lastStage = (stage == lenReg);
            end
            Store: begin
                lastStage = (stage == lenReg - len_t'(1));
            end
            default: begin
                lastStage = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            stage <= '0;
        end else if (go) begin
            case (state)
                Idle: begin
                    stage <= '0;
                    // data port wins a tie
                    if (dataEn) begin
                        state <= dataStore ? Store : Load;
                    end else if (fetchEn) begin
                        state <= Fetch;
                    end
                end
                default: begin
                    if (lastStage) begin
                        state <= Idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + len_t'(1);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            storeData <= dataWdata;
            if (dataEn) begin
                baseAddr <= dataAddr;
                lenReg   <= dataLen;
            end else begin
                baseAddr <= fetchAddr;
                lenReg   <= len_t'(INST_BYTES);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go && reading && (stage != '0)) begin
            asmWord[captIdx*8 +: 8] <= memRdata;
        end
    end

    always_comb begin
        memAddr   = baseAddr + addr_t'(stage);
        memWdata  = storeData[wrIdx*8 +: 8];
        memRe     = 1'b0;
        memWe     = 1'b0;
        fetchDone = 1'b0;
        dataDone  = 1'b0;
        owner     = OWN_FREE;
        case (state)
            Fetch: begin
                memRe     = go && !lastStage;
                fetchDone = go && lastStage;
                owner     = fetchDone ? OWN_FREE : OWN_FETCH;
            end
            Load: begin
                memRe    = go && !lastStage;
                dataDone = go && lastStage;
                owner    = dataDone ? OWN_FREE : OWN_DATA;
            end
            Store: begin
                // done goes out with the last byte written
                memWe    = go;
                dataDone = go && lastStage;
                owner    = dataDone ? OWN_FREE : OWN_DATA;
            end
            default: begin
                owner = OWN_FREE;
            end
        endcase
    end

    // top byte taken straight from the RAM in the done stage
    assign fetchInst = {memRdata, asmWord[23:0]};

    // zero extension by length, sign handled in the core
    always_comb begin
        case (lenReg)
            3'd1: begin
                dataRdata = {24'd0, memRdata};
            end
            3'd2: begin
                dataRdata = {16'd0, memRdata, asmWord[7:0]};
            end
            3'd4: begin
                dataRdata = {memRdata, asmWord[23:0]};
            end
            default: begin
                dataRdata = {8'd0, memRdata, asmWord[15:0]};
            end
        endcase
    end

endmodule

//--- src/memPkg.sv
package memPkg;

    // address and data widths seen by the core
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // access length in bytes: 1, 2 or 4
    typedef logic [2:0]  len_t;

    // who currently holds the RAM
    typedef logic [1:0]  owner_t;

    typedef enum logic [1:0] {
        Idle,
        Fetch,
        Load,
        Store
    } ctrlState_t;

    // 128 KiB of byte RAM
    localparam int RAM_ADDR_BITS = 17;

    // instructions are always fetched as a full word
    localparam int INST_BYTES = 4;

    localparam owner_t OWN_FREE  = 2'd0;
    localparam owner_t OWN_DATA  = 2'd1;
    localparam owner_t OWN_FETCH = 2'd2;

endpackage

//--- src/memSys.sv
`timescale 1ns/10ps

module memSys
    import memPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   ioFull,

    // instruction fetch port
    input  logic   fetchEn,
    input  addr_t  fetchAddr,
    output logic   fetchDone,
    output word_t  fetchInst,

    // load/store port
    input  logic   dataEn,
    input  logic   dataStore,
    input  len_t   dataLen,
    input  addr_t  dataAddr,
    input  word_t  dataWdata,
    output logic   dataDone,
    output word_t  dataRdata,

    output owner_t owner
);

    // controller to RAM
    addr_t memAddr;
    logic  memWe;
    byte_t memWdata;
    logic  memRe;
    byte_t memRdata;

    memCtrl ctrl0 (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .owner     (owner),
        .memAddr   (memAddr),
        .memWe     (memWe),
        .memWdata  (memWdata),
        .memRe     (memRe),
        .memRdata  (memRdata)
    );

    byteRam ram0 (
        .clk      (clk),
        .memAddr  (memAddr),
        .memWe    (memWe),
        .memWdata (memWdata),
        .memRe    (memRe),
        .memRdata (memRdata)
    );

endmodule

//--- test/memSysChecks.svh
`ifndef MEM_SYS_CHECKS_SVH
`define MEM_SYS_CHECKS_SVH

task automatic checkWord(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        mismatchCount++;
    end
endtask

task automatic checkOwner(input string name, input owner_t expected, input owner_t actual);
    if (expected !== actual) begin
        $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
        mismatchCount++;
    end
endtask

task automatic checkCycles(input string name, input int expected, input int actual);
    if (expected != actual) begin
        $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
        mismatchCount++;
    end
endtask

// random freeze when stalls are on
task automatic driveStall();
    if (stallOn) begin
        rdy    = ($unsigned($random(seed)) % 4) != 0;
        ioFull = ($unsigned($random(seed)) % 6) == 0;
    end else begin
        rdy    = 1'b1;
        ioFull = 1'b0;
    end
endtask

// one load or store, cycles counted from the accept window
task automatic dataAccess(input logic store, input len_t len, input int off,
                          input word_t wdata, output word_t rdata, output int cycles);
    @(negedge clk);
    driveStall();
    dataEn    = 1'b1;
    dataStore = store;
    dataLen   = len;
    dataAddr  = WIN_BASE + addr_t'(off);
    dataWdata = wdata;
    cycles    = 0;
    #1;
    while (!dataDone && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        driveStall();
        #1;
        cycles++;
        if (cycles == 1 && !stallOn) begin
            // a one-byte store is already in its done cycle
            checkOwner("data owner", (store && len == len_t'(1)) ? OWN_FREE : OWN_DATA,
                       owner);
        end
    end
    rdata = dataRdata;
    if (!dataDone) begin
        $display("timeout: data port saw no done after %0d cycles", cycles);
        otherCount++;
    end else begin
        checkOwner("data done owner", OWN_FREE, owner);
    end
    @(negedge clk);
    dataEn = 1'b0;
    driveStall();
endtask

task automatic fetchAccess(input int off, output word_t inst, output int cycles);
    @(negedge clk);
    driveStall();
    fetchEn   = 1'b1;
    fetchAddr = WIN_BASE + addr_t'(off);
    cycles    = 0;
    #1;
    while (!fetchDone && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        driveStall();
        #1;
        cycles++;
        if (cycles == 1 && !stallOn) begin
            checkOwner("fetch owner", OWN_FETCH, owner);
        end
    end
    inst = fetchInst;
    if (!fetchDone) begin
        $display("timeout: fetch port saw no done after %0d cycles", cycles);
        otherCount++;
    end else begin
        checkOwner("fetch done owner", OWN_FREE, owner);
    end
    @(negedge clk);
    fetchEn = 1'b0;
    driveStall();
endtask

`endif

//--- test/memSysTb.sv
`timescale 1ns/10ps

module memSysTb
    import memPkg::*;
();

    localparam addr_t WIN_BASE   = 32'h0000_0200;
    localparam int    WIN_BYTES  = 64;
    localparam int    WAIT_LIMIT = 300;

    logic   clk;
    logic   rst;
    logic   rdy;
    logic   ioFull;
    logic   fetchEn;
    addr_t  fetchAddr;
    logic   fetchDone;
    word_t  fetchInst;
    logic   dataEn;
    logic   dataStore;
    len_t   dataLen;
    addr_t  dataAddr;
    word_t  dataWdata;
    logic   dataDone;
    word_t  dataRdata;
    owner_t owner;

    integer seed;
    int     mismatchCount;
    int     otherCount;
    logic   stallOn;

    // mirror of the RAM window under test
    byte_t  model [WIN_BYTES];

    `include "memSysChecks.svh"

    memSys dut0 (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .ioFull    (ioFull),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataEn    (dataEn),
        .dataStore (dataStore),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWdata (dataWdata),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .owner     (owner)
    );

    always #20 clk = ~clk;

    // little endian, zero extended to a word
    function automatic word_t modelRead(input int off, input len_t len);
        word_t w;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            w[i*8 +: 8] = model[off + i];
        end
        return w;
    endfunction

    function automatic len_t pickLen();
        int r;
        r = int'($unsigned($random(seed)) % 3);
        return (r == 2) ? len_t'(4) : len_t'(r + 1);
    endfunction

    // leaves room for a full word inside the window
    function automatic int pickOffset();
        return int'($unsigned($random(seed)) % (WIN_BYTES - 3));
    endfunction

    task automatic storeLoadFetch(input int count);
        int    off;
        int    cycles;
        len_t  len;
        word_t w;
        word_t rdata;
        for (int n = 0; n < count; n++) begin
            off = pickOffset();
            len = pickLen();
            w   = $random(seed);
            dataAccess(1'b1, len, off, w, rdata, cycles);
            for (int i = 0; i < int'(len); i++) begin
                model[off + i] = w[i*8 +: 8];
            end
            if (!stallOn) begin
                checkCycles("store cycles", int'(len), cycles);
            end
        end
        for (int n = 0; n < count; n++) begin
            off = pickOffset();
            len = pickLen();
            dataAccess(1'b0, len, off, '0, rdata, cycles);
            checkWord("load data", modelRead(off, len), rdata);
            if (!stallOn) begin
                checkCycles("load cycles", int'(len) + 1, cycles);
            end
            off = pickOffset();
            fetchAccess(off, w, cycles);
            checkWord("fetch inst", modelRead(off, len_t'(INST_BYTES)), w);
            if (!stallOn) begin
                checkCycles("fetch cycles", INST_BYTES + 1, cycles);
            end
        end
    endtask

    // both ports raised together, data must go first
    task automatic raceRequests(input int dOff, input len_t dLen, input int fOff);
        word_t dRes;
        word_t fRes;
        int    n;
        logic  dSeen;
        logic  fSeen;
        @(negedge clk);
        driveStall();
        dataEn    = 1'b1;
        dataStore = 1'b0;
        dataLen   = dLen;
        dataAddr  = WIN_BASE + addr_t'(dOff);
        fetchEn   = 1'b1;
        fetchAddr = WIN_BASE + addr_t'(fOff);
        n     = 0;
        dSeen = 1'b0;
        fSeen = 1'b0;
        dRes  = '0;
        fRes  = '0;
        while (!fSeen && n < WAIT_LIMIT) begin
            @(negedge clk);
            driveStall();
            if (dSeen) begin
                dataEn = 1'b0;
            end
            #1;
            n++;
            if (n == 1) begin
                checkOwner("priority owner", OWN_DATA, owner);
            end
            if (dataDone) begin
                dSeen = 1'b1;
                dRes  = dataRdata;
            end
            if (fetchDone) begin
                fSeen = 1'b1;
                fRes  = fetchInst;
                if (!dSeen) begin
                    $display("fetch finished before the data load that had priority");
                    otherCount++;
                end
            end
        end
        if (!fSeen) begin
            $display("timeout: fetch never finished during the priority test");
            otherCount++;
        end
        @(negedge clk);
        dataEn  = 1'b0;
        fetchEn = 1'b0;
        driveStall();
        checkWord("priority load", modelRead(dOff, dLen), dRes);
        checkWord("priority fetch", modelRead(fOff, len_t'(INST_BYTES)), fRes);
    endtask

    initial begin
        word_t rdata;
        int    cycles;
        seed          = 86;
        mismatchCount = 0;
        otherCount    = 0;
        stallOn       = 1'b0;
        clk       = 1'b0;
        rst       = 1'b1;
        rdy       = 1'b1;
        ioFull    = 1'b0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataStore = 1'b0;
        dataLen   = len_t'(1);
        dataAddr  = '0;
        dataWdata = '0;
        for (int i = 0; i < WIN_BYTES; i++) begin
            model[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // idle after reset
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            #1;
            checkOwner("reset owner", OWN_FREE, owner);
            if (dataDone || fetchDone) begin
                $display("a done output went high with no request pending");
                otherCount++;
            end
        end

        // zero the window so the model matches
        for (int i = 0; i < WIN_BYTES; i += 4) begin
            dataAccess(1'b1, len_t'(4), i, '0, rdata, cycles);
        end

        storeLoadFetch(200);
        for (int n = 0; n < 20; n++) begin
            raceRequests(pickOffset(), pickLen(), pickOffset());
        end

        stallOn = 1'b1;
        storeLoadFetch(200);
        stallOn = 1'b0;

        $display("errors: %0d mismatch, %0d other", mismatchCount, otherCount);
        if (mismatchCount == 0 && otherCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
